/* busCoherencePkg.sv */
package busCoherencePkg;

    // two cores share the bus
    localparam int NUM_CPUS = 2;

    // data-cache block geometry
    localparam int BLOCK_WORDS = 2;
    localparam int WORD_BYTES = 4;
    localparam int WORD_CNT_W = $clog2(BLOCK_WORDS);

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic cpuIdx_t;

    // ACCESS means the current strobe completes this cycle
    typedef enum logic [1:0] {
        FREE,
        BUSY,
        ACCESS,
        ERROR
    } ramState_t;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_DREAD,
        OP_DWRITE,
        OP_IFETCH
    } busOp_t;

    typedef enum logic [2:0] {
        IDLE,
        SNOOP,
        DECIDE,
        PEERWB,
        FILL,
        WRITEBACK,
        FETCH
    } seqState_t;

endpackage

/* ramReqIf.sv */
`timescale 1ns/1ps

interface ramReqIf
    import busCoherencePkg::*;
();
    // strobes toward RAM, held until wordDone
    logic ren;
    logic wen;
    cpuIdx_t owner;
    logic isFetch;
    // peer supplies address and store data
    logic addrFromPeer;
    // ramstate is ACCESS under a live strobe
    logic wordDone;

    modport seq (
        output ren, wen, owner, isFetch, addrFromPeer,
        input  wordDone
    );

    modport ram (
        input  ren, wen, owner, isFetch, addrFromPeer,
        output wordDone
    );
endinterface

/* grantIf.sv */
`timescale 1ns/1ps

interface grantIf
    import busCoherencePkg::*;
();
    logic valid;
    busOp_t op;
    cpuIdx_t core;
    // requester's ccwrite captured with the grant
    logic exclusive;
    // one-cycle pulse at the final word
    logic releaseGrant;

    modport arb (
        output valid, op, core, exclusive,
        input  releaseGrant
    );

    modport seq (
        input  valid, op, core, exclusive,
        output releaseGrant
    );
endinterface

/* busArbiter.sv */
`timescale 1ns/1ps

module busArbiter
    import busCoherencePkg::*;
(
    input  logic                CLK,
    input  logic                nRST,
    input  logic [NUM_CPUS-1:0] iREN,
    input  logic [NUM_CPUS-1:0] dREN,
    input  logic [NUM_CPUS-1:0] dWEN,
    input  logic [NUM_CPUS-1:0] ccwrite,
    grantIf.arb                 grant
);

    busOp_t nextOp;
    cpuIdx_t nextCore;

    // scan lowest priority first so higher hits overwrite
    always_comb begin
        nextOp = OP_NONE;
        nextCore = '0;
        for (int i = NUM_CPUS - 1; i >= 0; i--) begin
            if (iREN[i]) begin
                nextOp = OP_IFETCH;
                nextCore = cpuIdx_t'(i);
            end
        end
        for (int i = NUM_CPUS - 1; i >= 0; i--) begin
            if (dWEN[i]) begin
                nextOp = OP_DWRITE;
                nextCore = cpuIdx_t'(i);
            end
        end
        for (int i = NUM_CPUS - 1; i >= 0; i--) begin
            if (dREN[i]) begin
                nextOp = OP_DREAD;
                nextCore = cpuIdx_t'(i);
            end
        end
    end

    // grant stays frozen until the sequencer lets go
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            grant.valid <= 1'b0;
            grant.op <= OP_NONE;
            grant.core <= '0;
            grant.exclusive <= 1'b0;
        end else if (grant.releaseGrant) begin
            grant.valid <= 1'b0;
        end else if (!grant.valid && nextOp != OP_NONE) begin
            grant.valid <= 1'b1;
            grant.op <= nextOp;
            grant.core <= nextCore;
            // only a read miss can ask for the block exclusive
            grant.exclusive <= (nextOp == OP_DREAD) && ccwrite[nextCore];
        end
    end

endmodule

/* snoopSequencer.sv */
`timescale 1ns/1ps

module snoopSequencer
    import busCoherencePkg::*;
(
    input  logic                CLK,
    input  logic                nRST,
    grantIf.seq                 grant,
    input  logic [NUM_CPUS-1:0] cctrans,
    input  addr_t               daddr [NUM_CPUS],
    ramReqIf.seq                ram,
    output logic [NUM_CPUS-1:0] ccwait,
    output logic [NUM_CPUS-1:0] ccinv,
    output addr_t               ccsnoopaddr [NUM_CPUS]
);

    seqState_t state;
    logic [WORD_CNT_W-1:0] wordCnt;
    logic lastWord;
    cpuIdx_t core;
    cpuIdx_t peer;

    assign core = grant.core;
    assign peer = ~grant.core;
    assign lastWord = (wordCnt == WORD_CNT_W'(BLOCK_WORDS - 1));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            wordCnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    wordCnt <= '0;
                    if (grant.valid) begin
                        case (grant.op)
                            OP_DREAD:  state <= SNOOP;
                            OP_DWRITE: state <= WRITEBACK;
                            OP_IFETCH: state <= FETCH;
                            default:   state <= IDLE;
                        endcase
                    end
                end
                SNOOP: state <= DECIDE;
                // peer answers with cctrans when it holds the block modified
                DECIDE: state <= cctrans[peer] ? PEERWB : FILL;
                PEERWB, FILL, WRITEBACK: begin
                    if (ram.wordDone) begin
                        if (lastWord) begin
                            wordCnt <= '0;
                            state <= (state == PEERWB) ? FILL : IDLE;
                        end else begin
                            wordCnt <= wordCnt + WORD_CNT_W'(1);
                        end
                    end
                end
                FETCH: begin
                    if (ram.wordDone) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // peer snoop signals
    always_comb begin
        ccwait = '0;
        ccinv = '0;
        for (int i = 0; i < NUM_CPUS; i++) begin
            ccsnoopaddr[i] = '0;
        end
        if (state == SNOOP || state == DECIDE || state == PEERWB) begin
            ccwait[peer] = 1'b1;
            ccsnoopaddr[peer] = daddr[core];
        end
        if (state == DECIDE && grant.exclusive) begin
            ccinv[peer] = 1'b1;
        end
    end

    // RAM strobes, owner is always the granted core
    always_comb begin
        ram.ren = 1'b0;
        ram.wen = 1'b0;
        ram.isFetch = 1'b0;
        ram.addrFromPeer = 1'b0;
        ram.owner = core;
        case (state)
            PEERWB: begin
                ram.wen = 1'b1;
                ram.addrFromPeer = 1'b1;
            end
            FILL:      ram.ren = 1'b1;
            WRITEBACK: ram.wen = 1'b1;
            FETCH: begin
                ram.ren = 1'b1;
                ram.isFetch = 1'b1;
            end
            default: ;
        endcase
    end

    assign grant.releaseGrant = ram.wordDone &&
        (state == FETCH || ((state == FILL || state == WRITEBACK) && lastWord));

endmodule

/* ramPort.sv */
`timescale 1ns/1ps

module ramPort
    import busCoherencePkg::*;
(
    ramReqIf.ram                ram,
    input  logic [NUM_CPUS-1:0] iREN,
    input  logic [NUM_CPUS-1:0] dREN,
    input  logic [NUM_CPUS-1:0] dWEN,
    input  addr_t               iaddr [NUM_CPUS],
    input  addr_t               daddr [NUM_CPUS],
    input  word_t               dstore [NUM_CPUS],
    input  word_t               ramload,
    input  ramState_t           ramstate,
    output logic                ramREN,
    output logic                ramWEN,
    output addr_t               ramaddr,
    output word_t               ramstore,
    output word_t               iload [NUM_CPUS],
    output word_t               dload [NUM_CPUS],
    output logic [NUM_CPUS-1:0] iwait,
    output logic [NUM_CPUS-1:0] dwait
);

    // core whose data port feeds the RAM this word
    cpuIdx_t src;
    logic dataServes;
    logic fetchServes;

    assign src = ram.addrFromPeer ? ~ram.owner : ram.owner;
    assign ram.wordDone = (ramstate == ACCESS) && (ram.ren || ram.wen);

    assign ramREN = ram.ren;
    assign ramWEN = ram.wen;
    assign ramaddr = ram.isFetch ? iaddr[ram.owner] : daddr[src];
    assign ramstore = dstore[src];

    always_comb begin
        for (int i = 0; i < NUM_CPUS; i++) begin
            dataServes = (ram.ren || ram.wen) && !ram.isFetch && (src == cpuIdx_t'(i));
            fetchServes = ram.ren && ram.isFetch && (ram.owner == cpuIdx_t'(i));

            iload[i] = fetchServes ? ramload : '0;
            dload[i] = (dataServes && ram.ren) ? ramload : '0;

            // wait follows the request level and drops on a served word
            iwait[i] = iREN[i] && !(ram.wordDone && fetchServes);
            // peer sees a wait on its writeback words even without a request
            dwait[i] = (dREN[i] || dWEN[i] || (ram.addrFromPeer && dataServes)) &&
                       !(ram.wordDone && dataServes);
        end
    end

endmodule

/* busController.sv */
`timescale 1ns/1ps

module busController
    import busCoherencePkg::*;
(
    input  logic                CLK,
    input  logic                nRST,
    // per-core requests
    input  logic [NUM_CPUS-1:0] iREN,
    input  addr_t               iaddr [NUM_CPUS],
    input  logic [NUM_CPUS-1:0] dREN,
    input  logic [NUM_CPUS-1:0] dWEN,
    input  addr_t               daddr [NUM_CPUS],
    input  word_t               dstore [NUM_CPUS],
    input  logic [NUM_CPUS-1:0] ccwrite,
    input  logic [NUM_CPUS-1:0] cctrans,
    // per-core responses
    output logic [NUM_CPUS-1:0] iwait,
    output word_t               iload [NUM_CPUS],
    output logic [NUM_CPUS-1:0] dwait,
    output word_t               dload [NUM_CPUS],
    output logic [NUM_CPUS-1:0] ccwait,
    output logic [NUM_CPUS-1:0] ccinv,
    output addr_t               ccsnoopaddr [NUM_CPUS],
    // RAM side
    output logic                ramREN,
    output logic                ramWEN,
    output addr_t               ramaddr,
    output word_t               ramstore,
    input  word_t               ramload,
    input  ramState_t           ramstate
);

    grantIf grantBus ();
    ramReqIf ramBus ();

    busArbiter arbiter (
        .CLK(CLK), .nRST(nRST), .iREN(iREN), .dREN(dREN), .dWEN(dWEN),
        .ccwrite(ccwrite), .grant(grantBus.arb)
    );

    snoopSequencer sequencer (
        .CLK(CLK), .nRST(nRST), .grant(grantBus.seq), .cctrans(cctrans), .daddr(daddr),
        .ram(ramBus.seq), .ccwait(ccwait), .ccinv(ccinv), .ccsnoopaddr(ccsnoopaddr)
    );

    ramPort port (
        .ram(ramBus.ram), .iREN(iREN), .dREN(dREN), .dWEN(dWEN), .iaddr(iaddr),
        .daddr(daddr), .dstore(dstore), .ramload(ramload), .ramstate(ramstate),
        .ramREN(ramREN), .ramWEN(ramWEN), .ramaddr(ramaddr), .ramstore(ramstore),
        .iload(iload), .dload(dload), .iwait(iwait), .dwait(dwait)
    );

endmodule

/* tbRamModel.sv */
`timescale 1ns/1ps

module tbRamModel
    import busCoherencePkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  int        latency,
    input  logic      ren,
    input  logic      wen,
    input  addr_t     addr,
    input  word_t     store,
    output word_t     load,
    output ramState_t state
);

    // word array, read back by the testbench
    word_t mem [256];
    int cnt;

    // each word starts from its own byte address
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hc0de_0000 ^ (word_t'(i) << 2);
        end
    end

    // busy for latency-1 cycles, then the word completes
    always_comb begin
        if (!(ren || wen)) begin
            state = FREE;
        end else if (cnt >= latency - 1) begin
            state = ACCESS;
        end else begin
            state = BUSY;
        end
    end

    assign load = ren ? mem[addr[9:2]] : '0;

    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cnt <= 0;
        end else if (state == ACCESS) begin
            cnt <= 0;
            if (wen) begin
                mem[addr[9:2]] <= store;
            end
        end else if (ren || wen) begin
            cnt <= cnt + 1;
        end
    end

endmodule

/* busControllerTb.sv */
`timescale 1ns/1ps

module busControllerTb
    import busCoherencePkg::*;
();

    logic CLK = 1'b0;
    logic nRST;
    logic [NUM_CPUS-1:0] iREN, dREN, dWEN, ccwrite, cctrans;
    logic [NUM_CPUS-1:0] iwait, dwait, ccwait, ccinv;
    addr_t iaddr [NUM_CPUS];
    addr_t daddr [NUM_CPUS];
    addr_t ccsnoopaddr [NUM_CPUS];
    word_t dstore [NUM_CPUS];
    word_t iload [NUM_CPUS];
    word_t dload [NUM_CPUS];
    logic ramREN, ramWEN;
    addr_t ramaddr;
    word_t ramstore, ramload;
    ramState_t ramstate;
    int latency;
    // record count first, then nine words per record
    word_t cases [0:127];
    int mismatches = 0;
    int failures = 0;

    busController uut (.*);

    tbRamModel ram (
        .CLK(CLK), .nRST(nRST), .latency(latency), .ren(ramREN), .wen(ramWEN),
        .addr(ramaddr), .store(ramstore), .load(ramload), .state(ramstate)
    );

    always #2 CLK = ~CLK;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic awaitFetch(input cpuIdx_t c, input word_t exp);
        int t;
        t = 0;
        do begin
            @(negedge CLK);
            t++;
        end while (iwait[c] && t < 200);
        if (iwait[c]) begin
            $display("timeout, iwait of core %0d never fell", c);
            failures++;
        end else begin
            compare("iload", iload[c], exp);
        end
        iREN[c] = 1'b0;
    endtask

    // requester walks its block, the peer answers snoops and writes back when dirty
    task automatic dataBlock(input int r);
        addr_t a;
        cpuIdx_t c;
        cpuIdx_t p;
        int t;
        int words;
        int peerWords;
        int invs;
        int snoops;
        logic peerStep;
        logic ownStep;
        a = cases[r+2];
        c = cases[r+1][0];
        p = ~c;
        t = 0;
        words = 0;
        peerWords = 0;
        invs = 0;
        snoops = 0;
        peerStep = 1'b0;
        ownStep = 1'b0;
        daddr[c] = a;
        dstore[c] = cases[r+3];
        ccwrite[c] = cases[r+6][0];
        dREN[c] = (cases[r] != 32'd2);
        dWEN[c] = (cases[r] == 32'd2);
        daddr[p] = a;
        dstore[p] = cases[r+3];
        cctrans[p] = cases[r+5][0];
        while (words < BLOCK_WORDS && t < 200) begin
            @(negedge CLK);
            t++;
            if (ccwait[p]) begin
                snoops++;
                compare("ccsnoopaddr", ccsnoopaddr[p], a);
            end
            if (ccinv[p]) begin
                invs++;
            end
            if (iREN[p] && !iwait[p]) begin
                $display("fetch of core %0d finished before the data block", p);
                failures++;
            end
            // a written word commits on the rising edge after its wait falls
            if (peerStep) begin
                daddr[p] = a + addr_t'(WORD_BYTES);
                dstore[p] = cases[r+4];
                peerStep = 1'b0;
            end
            if (ownStep) begin
                daddr[c] = a + addr_t'(WORD_BYTES);
                dstore[c] = cases[r+4];
                ownStep = 1'b0;
            end
            // peer writeback word accepted
            if (ccwait[p] && ramWEN && !dwait[p]) begin
                peerWords++;
                peerStep = 1'b1;
            end
            if (!dwait[c]) begin
                if (words == 0) begin
                    compare("peer words", peerWords, (cases[r+5] != 0) ? 2 : 0);
                end
                if (cases[r] != 32'd2) begin
                    compare("dload", dload[c], (words == 0) ? cases[r+7] : cases[r+8]);
                    daddr[c] = a + addr_t'(WORD_BYTES);
                end else begin
                    ownStep = 1'b1;
                end
                words++;
            end
        end
        if (words < BLOCK_WORDS) begin
            $display("timeout, dwait of core %0d did not fall for every word", c);
            failures++;
        end
        dREN[c] = 1'b0;
        dWEN[c] = 1'b0;
        ccwrite[c] = 1'b0;
        cctrans[p] = 1'b0;
        compare("ccinv pulses", invs, cases[r+6]);
        // only a read miss snoops the peer
        compare("ccwait raised", 32'(snoops != 0), 32'(cases[r] != 32'd2));
    endtask

    initial begin
        int n;
        int r;
        cpuIdx_t c;
        void'($urandom(32'hef77_6d72));
        nRST = 1'b0;
        iREN = '0;
        dREN = '0;
        dWEN = '0;
        ccwrite = '0;
        cctrans = '0;
        for (int i = 0; i < NUM_CPUS; i++) begin
            iaddr[i] = '0;
            daddr[i] = '0;
            dstore[i] = '0;
        end
        latency = 1;
        $readmemh("busCases.mem", cases);
        repeat (16) @(negedge CLK);
        nRST = 1'b1;
        // idle bus stays quiet
        repeat (10) begin
            @(negedge CLK);
            compare("ramREN", 32'(ramREN), 0);
            compare("ramWEN", 32'(ramWEN), 0);
            compare("ccwait", 32'(ccwait), 0);
            compare("ccinv", 32'(ccinv), 0);
        end
        n = int'(cases[0]);
        for (int k = 0; k < n; k++) begin
            r = 1 + 9 * k;
            c = cases[r+1][0];
            latency = 1 + int'($urandom % 3);
            if (cases[r] == 32'd1) begin
                iaddr[c] = cases[r+2];
                iREN[c] = 1'b1;
                awaitFetch(c, cases[r+7]);
            end else begin
                // peer fetch raised together with the read miss
                if (cases[r] == 32'd4) begin
                    iaddr[~c] = cases[r+3];
                    iREN[~c] = 1'b1;
                end
                dataBlock(r);
                if (cases[r] == 32'd4) begin
                    awaitFetch(~c, cases[r+4]);
                end
            end
            repeat (2) @(negedge CLK);
            if (cases[r] == 32'd2 || cases[r+5] != 0) begin
                compare("ram word 0", ram.mem[cases[r+2][9:2]], cases[r+7]);
                compare("ram word 1", ram.mem[cases[r+2][9:2] + 8'd1], cases[r+8]);
            end
        end
        $display("%0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* busCases.mem */
// first word is the record count
// columns are op core addr store0 store1 dirty excl expect0 expect1
// op 1 fetch, 2 writeback, 3 read miss, 4 read miss with peer fetch of iaddr store0
0a
1 0 00000100 00000000 00000000 0 0 c0de0100 00000000
1 1 00000204 00000000 00000000 0 0 c0de0204 00000000
2 0 00000040 11110040 22220044 0 0 11110040 22220044
2 1 00000080 33330080 44440084 0 0 33330080 44440084
3 0 00000040 00000000 00000000 0 0 11110040 22220044
3 1 000000c0 00000000 00000000 0 1 c0de00c0 c0de00c4
3 0 00000300 aaaa0300 bbbb0304 1 1 aaaa0300 bbbb0304
3 1 00000080 55550080 66660084 1 0 55550080 66660084
4 0 00000140 000003f0 c0de03f0 0 0 c0de0140 c0de0144
3 1 00000300 00000000 00000000 0 0 aaaa0300 bbbb0304

/* flist.f */
busCoherencePkg.sv
ramReqIf.sv
grantIf.sv
busArbiter.sv
snoopSequencer.sv
ramPort.sv
busController.sv
tbRamModel.sv
busControllerTb.sv

/* Makefile */
TOP = busControllerTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module busController

sim:
	verilator --binary --timing -f flist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
